// ==== rtl/adapter_bus_pkg.sv ====
// Widths are fixed for a 32-bit slave on a 128-bit master with word addressing and no parameters
`default_nettype none

package adapter_bus_pkg;

    // The slave side carries one 32-bit word per address
    localparam int SLAVE_DATA_WIDTH  = 32;
    localparam int MASTER_DATA_WIDTH = 128; // Four slave words side by side

    // Number of slave words that share one master word
    localparam int PACKING_FACTOR = MASTER_DATA_WIDTH / SLAVE_DATA_WIDTH;

    // The low address bits pick the slave word inside the master word
    localparam int LANE_WIDTH = $clog2(PACKING_FACTOR);

    localparam int SLAVE_ADDR_WIDTH  = 8;                             // Slave word address
    localparam int MASTER_ADDR_WIDTH = SLAVE_ADDR_WIDTH - LANE_WIDTH; // Upper slave address bits

    // One enable bit for every byte on each bus
    localparam int SLAVE_BE_WIDTH  = SLAVE_DATA_WIDTH / 8;
    localparam int MASTER_BE_WIDTH = MASTER_DATA_WIDTH / 8;

    // Data words on each side
    typedef logic [SLAVE_DATA_WIDTH-1:0]  slave_word_t;
    typedef logic [MASTER_DATA_WIDTH-1:0] master_word_t;

    // Word addresses on each side
    typedef logic [SLAVE_ADDR_WIDTH-1:0]  slave_addr_t;
    typedef logic [MASTER_ADDR_WIDTH-1:0] master_addr_t;

    typedef logic [LANE_WIDTH-1:0] lane_t; // Slave word position in a master word

    // Byte enables on each side
    typedef logic [SLAVE_BE_WIDTH-1:0]  slave_be_t;
    typedef logic [MASTER_BE_WIDTH-1:0] master_be_t;

endpackage

`default_nettype wire

// ==== rtl/adapter_port_pkg.sv ====
// Request bundles assume read and write are never high together, and the tag tracks reads only
`default_nettype none

package adapter_port_pkg;

    import adapter_bus_pkg::*;

    // Request as the narrow slave presents it
    // The slave holds every field steady while wait request is high
    typedef struct packed {
        slave_addr_t address;   // Word address in slave words
        slave_be_t   byte_en;   // One bit per byte of the slave word
        logic        write;     // Write strobe
        logic        read;      // Read strobe
        slave_word_t writedata; // Only meaningful with write high
    } slave_req_t;

    // Request as the wide master sees it
    // Only one lane group of byte_en is ever nonzero
    typedef struct packed {
        master_addr_t address;   // Word address in master words
        master_be_t   byte_en;   // Slave enables placed in the chosen lane
        logic         write;     // Same strobe as the slave
        logic         read;      // Same strobe as the slave
        master_word_t writedata; // Slave data copied into every lane
    } master_req_t;

    // Record of one accepted read, held for the cycle its data comes back
    typedef struct packed {
        logic  valid; // High only in the cycle the master data is on the bus
        lane_t lane;  // Which slave word to return
    } read_tag_t;

endpackage

`default_nettype wire

// ==== rtl/request_formatter.sv ====
// Purely combinational, so slave request timing passes straight to the master in the same cycle
`timescale 1ns/100ps
`default_nettype none

module request_formatter (
    input  wire adapter_port_pkg::slave_req_t   slave_req,
    output adapter_port_pkg::master_req_t       master_req
);

    import adapter_bus_pkg::*;

    master_addr_t word_addr; // Master word holding the slave word
    lane_t        lane;      // Slave word position inside it
    master_be_t   lane_be;   // Slave byte enables moved into their lane
    master_word_t wide_data; // Write data seen by every lane

    // Drop the lane bits to get the master word address
    assign word_addr = slave_req.address[SLAVE_ADDR_WIDTH-1:LANE_WIDTH];

    // The low address bits choose the lane
    assign lane = slave_req.address[LANE_WIDTH-1:0];

    // Build the wide byte enable one lane group at a time
    always_comb begin
        lane_be = '0; // All lanes disabled unless selected below
        for (int i = 0; i < PACKING_FACTOR; i++) begin
            if (lane == lane_t'(i)) begin
                // Only the addressed group gets the slave enables
                lane_be[i*SLAVE_BE_WIDTH +: SLAVE_BE_WIDTH] = slave_req.byte_en;
            end
        end
    end

    // Copy the slave word into each lane
    // The byte enables decide which copy the master actually writes
    assign wide_data = {PACKING_FACTOR{slave_req.writedata}};

    // Assemble the master request
    always_comb begin
        master_req.address   = word_addr;
        master_req.byte_en   = lane_be;
        master_req.write     = slave_req.write; // Strobes pass through unchanged
        master_req.read      = slave_req.read;
        master_req.writedata = wide_data;
    end

endmodule

`default_nettype wire

// ==== rtl/lane_tracker.sv ====
// Assumes the master returns read data exactly one cycle after acceptance, with no other latency
`timescale 1ns/100ps
`default_nettype none

module lane_tracker (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire adapter_port_pkg::slave_req_t   slave_req,
    input  wire                                 master_waitreq,
    output adapter_port_pkg::read_tag_t         read_tag
);

    import adapter_bus_pkg::*;
    import adapter_port_pkg::*;

    logic      read_accept; // A read leaves for the master this cycle
    read_tag_t next_tag;    // Tag to be held for the data cycle

    // A read counts only when the master is not stalling
    // Under wait request the slave repeats the same read next cycle
    assign read_accept = slave_req.read && !master_waitreq;

    always_comb begin
        next_tag.valid = read_accept;
        // The lane is taken every cycle and only matters when valid is set
        next_tag.lane  = slave_req.address[LANE_WIDTH-1:0];
    end

    // One register stage lines the tag up with the returning master data
    // Back to back reads simply overwrite it, since each tag lives one cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            read_tag <= '0; // No read outstanding after reset
        end else begin
            read_tag <= next_tag;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/readdata_selector.sv ====
// Expects the tag and the master read data in the same cycle, and adds one output register
`timescale 1ns/100ps
`default_nettype none

module readdata_selector (
    input  wire                                 clock,
    input  wire                                 reset,
    input  wire adapter_port_pkg::read_tag_t    read_tag,
    input  wire adapter_bus_pkg::master_word_t  master_readdata,
    output adapter_bus_pkg::slave_word_t        slave_readdata,
    output logic                                slave_readdatavalid
);

    import adapter_bus_pkg::*;

    // View the wide data as a row of slave words, lane 0 in the low bits
    slave_word_t [PACKING_FACTOR-1:0] lanes;

    slave_word_t lane_word; // Word chosen by the tag

    assign lanes = master_readdata;

    // The tag lane indexes straight into the row
    assign lane_word = lanes[read_tag.lane];

    // Register the chosen word for the slave
    // This stage is the read pipeline and adds the second cycle of latency
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            slave_readdata      <= '0;
            slave_readdatavalid <= 1'b0;
        end else begin
            slave_readdatavalid <= read_tag.valid; // Valid pulses once per tracked read
            if (read_tag.valid) begin
                slave_readdata <= lane_word;
            end
            // Without a tag the last returned word stays on the bus
        end
    end

endmodule

`default_nettype wire

// ==== rtl/avmm_width_adapter.sv ====
// Slave requests are not registered, so slave wait request is exactly the master wait request
`timescale 1ns/100ps
`default_nettype none

module avmm_width_adapter (
    input  wire                                 clock,
    input  wire                                 reset,
    // Narrow slave port
    input  wire adapter_port_pkg::slave_req_t   slave_req,
    output logic                                slave_waitreq,
    output adapter_bus_pkg::slave_word_t        slave_readdata,
    output logic                                slave_readdatavalid,
    // Wide master port
    output adapter_port_pkg::master_req_t       master_req,
    input  wire                                 master_waitreq,
    input  wire adapter_bus_pkg::master_word_t  master_readdata
);

    import adapter_port_pkg::*;

    read_tag_t read_tag; // Lane of the read whose data is on the master bus

    // Stalls come straight from the master
    // There is no request buffering here to absorb them
    assign slave_waitreq = master_waitreq;

    // Request path with zero latency
    request_formatter u_request_formatter (
        .slave_req  (slave_req),
        .master_req (master_req)
    );

    // Remembers the lane of every accepted read for one cycle
    lane_tracker u_lane_tracker (
        .clock          (clock),
        .reset          (reset),
        .slave_req      (slave_req),
        .master_waitreq (master_waitreq),
        .read_tag       (read_tag)
    );

    // Picks and registers the slave word
    // Data reaches the slave two cycles after the read was accepted
    readdata_selector u_readdata_selector (
        .clock               (clock),
        .reset               (reset),
        .read_tag            (read_tag),
        .master_readdata     (master_readdata),
        .slave_readdata      (slave_readdata),
        .slave_readdatavalid (slave_readdatavalid)
    );

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
// Free-running 8 ns clock, reset high from time zero and released on a falling edge after three cycles
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clock,
    output logic reset
);

    localparam time HALF_PERIOD = 4ns; // Half of the 8 ns period
    localparam int  RESET_CYCLES = 3;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Release away from the rising edge so the flops see a clean deassertion
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_avmm_width_adapter.sv ====
// Master model stalls at random about one cycle in three and answers reads one cycle late, seed 86
`timescale 1ns/100ps
`default_nettype none

module tb_avmm_width_adapter;

    import adapter_bus_pkg::*;
    import adapter_port_pkg::*;

    localparam int MEM_DEPTH    = 64;                         // Master words in the model
    localparam int SB_DEPTH     = MEM_DEPTH * PACKING_FACTOR; // Same storage seen as slave words
    localparam int TABLE_SIZE   = 28;
    localparam int RANDOM_SEED  = 86;
    localparam int RESET_LIMIT  = 10;  // Cycles allowed for reset to drop
    localparam int ACCEPT_LIMIT = 50;  // Cycles allowed for one request to get through
    localparam int DRAIN_LIMIT  = 20;  // Cycles allowed for the last reads to return
    localparam int QUIET_CYCLES = 4;   // Idle cycles that must stay free of data valid

    typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_t;

    // One table row, expected is only used by reads
    typedef struct packed {
        op_t         op;
        slave_addr_t address;
        slave_be_t   byte_en;
        slave_word_t data;
        slave_word_t expected;
    } stim_row_t;

    logic         clock;
    logic         reset;
    slave_req_t   slave_req;
    logic         slave_waitreq;
    slave_word_t  slave_readdata;
    logic         slave_readdatavalid;
    master_req_t  master_req;
    logic         master_waitreq;
    master_word_t master_readdata;

    master_word_t memory [MEM_DEPTH];    // Wide memory behind the master port
    slave_word_t  scoreboard [SB_DEPTH]; // Narrow mirror of the same memory
    stim_row_t    table_rows [TABLE_SIZE];
    slave_word_t  expect_q [$];          // Read data still owed to the slave, in order
    int           accept_q [$];          // Cycle in which each of those reads was accepted
    logic         pending_read;          // Read accepted at the last rising edge
    master_addr_t pending_addr;
    int           cycle_count = 0;

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    avmm_width_adapter UUT (
        .clock               (clock),
        .reset               (reset),
        .slave_req           (slave_req),
        .slave_waitreq       (slave_waitreq),
        .slave_readdata      (slave_readdata),
        .slave_readdatavalid (slave_readdatavalid),
        .master_req          (master_req),
        .master_waitreq      (master_waitreq),
        .master_readdata     (master_readdata)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping at the first failed check");
    endtask

    // Rows are grouped by behavior, expected words worked out by hand from the writes above them
    task automatic load_table();
        table_rows[0]  = '{OP_WRITE, 8'h14, 4'hf, 32'h1111_1111, 32'h0}; // Four lanes of word 5
        table_rows[1]  = '{OP_WRITE, 8'h15, 4'hf, 32'h2222_2222, 32'h0};
        table_rows[2]  = '{OP_WRITE, 8'h16, 4'hf, 32'h3333_3333, 32'h0};
        table_rows[3]  = '{OP_WRITE, 8'h17, 4'hf, 32'h4444_4444, 32'h0};
        table_rows[4]  = '{OP_READ,  8'h14, 4'hf, 32'h0, 32'h1111_1111};
        table_rows[5]  = '{OP_READ,  8'h15, 4'hf, 32'h0, 32'h2222_2222};
        table_rows[6]  = '{OP_READ,  8'h16, 4'hf, 32'h0, 32'h3333_3333};
        table_rows[7]  = '{OP_READ,  8'h17, 4'hf, 32'h0, 32'h4444_4444};
        // Bytes 0 and 2 change, bytes 1 and 3 keep the 22 pattern
        table_rows[8]  = '{OP_WRITE, 8'h15, 4'b0101, 32'haabb_ccdd, 32'h0};
        table_rows[9]  = '{OP_READ,  8'h15, 4'hf, 32'h0, 32'h22bb_22dd};
        table_rows[10] = '{OP_WRITE, 8'h24, 4'hf, 32'ha0a0_a0a0, 32'h0}; // Word 9 lanes 0, 1, 3
        table_rows[11] = '{OP_WRITE, 8'h25, 4'hf, 32'ha1a1_a1a1, 32'h0};
        table_rows[12] = '{OP_WRITE, 8'h27, 4'hf, 32'ha3a3_a3a3, 32'h0};
        table_rows[13] = '{OP_WRITE, 8'h26, 4'hf, 32'hc2c2_c2c2, 32'h0}; // Lane 2 last
        table_rows[14] = '{OP_READ,  8'h24, 4'hf, 32'h0, 32'ha0a0_a0a0};
        table_rows[15] = '{OP_READ,  8'h25, 4'hf, 32'h0, 32'ha1a1_a1a1};
        table_rows[16] = '{OP_READ,  8'h27, 4'hf, 32'h0, 32'ha3a3_a3a3};
        table_rows[17] = '{OP_READ,  8'h26, 4'hf, 32'h0, 32'hc2c2_c2c2};
        // Back to back reads hopping over lanes and words
        table_rows[18] = '{OP_READ,  8'h16, 4'hf, 32'h0, 32'h3333_3333};
        table_rows[19] = '{OP_READ,  8'h27, 4'hf, 32'h0, 32'ha3a3_a3a3};
        table_rows[20] = '{OP_READ,  8'h14, 4'hf, 32'h0, 32'h1111_1111};
        table_rows[21] = '{OP_READ,  8'h25, 4'hf, 32'h0, 32'ha1a1_a1a1};
        table_rows[22] = '{OP_READ,  8'h15, 4'hf, 32'h0, 32'h22bb_22dd};
        table_rows[23] = '{OP_READ,  8'h3c, 4'hf, 32'h0, 32'h0000_0000}; // Never written
        table_rows[24] = '{OP_WRITE, 8'hff, 4'b1000, 32'h1234_5678, 32'h0}; // Top byte of last word
        table_rows[25] = '{OP_READ,  8'hff, 4'hf, 32'h0, 32'h1200_0000};
        table_rows[26] = '{OP_READ,  8'h17, 4'hf, 32'h0, 32'h4444_4444};
        table_rows[27] = '{OP_READ,  8'h26, 4'hf, 32'h0, 32'hc2c2_c2c2};
    endtask

    // Drives one row and holds it until the DUT accepts it
    task automatic apply_row(input stim_row_t row);
        int          waited;
        slave_word_t expected;
        waited                = 0;
        slave_req.address     = row.address;
        slave_req.byte_en     = row.byte_en;
        slave_req.write       = (row.op == OP_WRITE);
        slave_req.read        = (row.op == OP_READ);
        slave_req.writedata   = (row.op == OP_WRITE) ? row.data : $urandom; // Noise on reads
        @(posedge clock);
        while (slave_waitreq !== 1'b0) begin
            assert (slave_waitreq === master_waitreq)
                else stop_with_failure($sformatf("error slave_waitreq: 0x%0h, master_waitreq 0x%0h",
                                                 slave_waitreq, master_waitreq));
            waited++;
            assert (waited < ACCEPT_LIMIT)
                else stop_with_failure($sformatf("request to address 0x%02h was never accepted",
                                                 row.address));
            @(posedge clock);
        end
        // Accepted at this edge, the counter still shows the acceptance cycle
        if (row.op == OP_WRITE) begin
            for (int b = 0; b < SLAVE_BE_WIDTH; b++) begin
                if (row.byte_en[b]) begin
                    scoreboard[row.address][b*8 +: 8] = row.data[b*8 +: 8];
                end
            end
        end else begin
            expected = scoreboard[row.address];
            assert (expected == row.expected)
                else stop_with_failure($sformatf("table expects 0x%08h at 0x%02h, mirror has 0x%08h",
                                                 row.expected, row.address, expected));
            expect_q.push_back(expected);
            accept_q.push_back(cycle_count);
        end
        @(negedge clock); // Next row starts at once, so reads can go back to back
    endtask

    always @(posedge clock) cycle_count <= cycle_count + 1;

    // Master memory model, writes honor every byte enable
    always @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int w = 0; w < MEM_DEPTH; w++) begin
                memory[w] <= '0;
            end
            pending_read <= 1'b0;
            pending_addr <= '0;
        end else begin
            pending_read <= master_req.read && !master_waitreq;
            pending_addr <= master_req.address;
            if (master_req.write && !master_waitreq) begin
                for (int b = 0; b < MASTER_BE_WIDTH; b++) begin
                    if (master_req.byte_en[b]) begin
                        memory[master_req.address][b*8 +: 8] <= master_req.writedata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Stalls and read data change on the falling edge
    always @(negedge clock) begin
        master_waitreq <= ($urandom % 3) == 0;
        if (pending_read) begin
            master_readdata <= memory[pending_addr]; // Data for the read one cycle back
        end else begin
            master_readdata <= {$urandom, $urandom, $urandom, $urandom}; // Junk outside the slot
        end
    end

    // Every data valid must match the oldest outstanding read, two cycles after its acceptance
    always @(negedge clock) begin
        if (reset === 1'b0) begin
            assert (!$isunknown(slave_readdatavalid))
                else stop_with_failure("slave_readdatavalid is unknown after reset");
            if (slave_readdatavalid) begin
                assert (expect_q.size() > 0)
                    else stop_with_failure("data valid came with no read outstanding");
                assert (slave_readdata == expect_q[0])
                    else stop_with_failure($sformatf("error slave_readdata: 0x%08h, expected 0x%08h",
                                                     slave_readdata, expect_q[0]));
                assert (cycle_count == accept_q[0] + 2)
                    else stop_with_failure($sformatf("read data came %0d cycles after acceptance",
                                                     cycle_count - accept_q[0]));
                void'(expect_q.pop_front());
                void'(accept_q.pop_front());
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(RANDOM_SEED)); // The only seeding of the run
        slave_req       = '0;
        master_waitreq  = 1'b0;
        master_readdata = '0;
        for (int a = 0; a < SB_DEPTH; a++) begin
            scoreboard[a] = '0; // Mirrors the cleared memory
        end
        load_table();

        waited = 0;
        @(posedge clock);
        while (reset !== 1'b0) begin
            waited++;
            assert (waited < RESET_LIMIT) else stop_with_failure("reset was never released");
            @(posedge clock);
        end
        @(negedge clock);
        assert (slave_readdatavalid === 1'b0)
            else stop_with_failure($sformatf("error slave_readdatavalid: 0x%0h after reset",
                                             slave_readdatavalid));

        for (int r = 0; r < TABLE_SIZE; r++) begin
            apply_row(table_rows[r]);
        end
        slave_req.write = 1'b0; // Bus goes idle
        slave_req.read  = 1'b0;

        // Each accepted read owes exactly one data valid, so the queue must empty
        waited = 0;
        @(posedge clock);
        while (expect_q.size() != 0) begin
            waited++;
            assert (waited < DRAIN_LIMIT)
                else stop_with_failure($sformatf("%0d reads never returned", expect_q.size()));
            @(posedge clock);
        end
        repeat (QUIET_CYCLES) @(posedge clock); // Any stray data valid shows up here

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/adapter_bus_pkg.sv
rtl/adapter_port_pkg.sv
rtl/request_formatter.sv
rtl/lane_tracker.sv
rtl/readdata_selector.sv
rtl/avmm_width_adapter.sv
testbench/clock_gen.sv
testbench/tb_avmm_width_adapter.sv

// ==== Makefile ====
# Verilator build and run of the width adapter testbench

TOP := tb_avmm_width_adapter
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)

# The verdict comes from the log, so a failing run also fails make
run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
